// ==== source/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

  // cache geometry.
  localparam int LINES          = 64;
  localparam int WORDS_PER_LINE = 4;

  // address field positions.
  localparam int TAG_LSB    = 10;
  localparam int INDEX_LSB  = 4;
  localparam int OFFSET_LSB = 2;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;

  // tag is everything above the index.
  typedef logic [31-TAG_LSB:0] tag_t;

  typedef logic [TAG_LSB-INDEX_LSB-1:0] index_t;

  // four words, word 0 in the low bits.
  typedef logic [WORDS_PER_LINE*32-1:0] line_t;

  // instruction cache controller states.
  typedef enum logic [2:0] {
    IDLE,
    CHECK,
    REFILL_ADDR,
    REFILL_DATA,
    FILL,
    FILL_WAIT
  } cache_state_t;

endpackage

`default_nettype wire

// ==== source/cache_ram.sv ====
`default_nettype none

module cache_ram #(
  parameter int WIDTH = 32
) (
  input  logic              clk,
  input  cache_pkg::index_t addr,
  input  logic              we,
  input  logic [WIDTH-1:0]  wdata,
  output logic [WIDTH-1:0]  rdata
);
  import cache_pkg::*;

  logic [WIDTH-1:0] mem [LINES];

  // read returns the old entry when written in the same cycle.
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

endmodule

`default_nettype wire

// ==== source/l1i_cache.sv ====
`default_nettype none

module l1i_cache (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_req,
  input  cache_pkg::addr_t i_addr,
  output cache_pkg::word_t i_data,
  output logic             i_wait,
  output logic             req,
  output cache_pkg::addr_t addr,
  input  cache_pkg::word_t rdata,
  input  logic             wait_in
);
  import cache_pkg::*;

  cache_state_t state;
  cache_state_t state_next;

  index_t cur_index;
  index_t array_index;
  index_t index_r;
  tag_t   tag_out;
  line_t  line_out;
  line_t  line_buf;

  logic [LINES-1:0] valid;
  logic [$clog2(WORDS_PER_LINE)-1:0] beat_cnt;

  logic hit;
  logic beat;
  logic last_beat;
  logic fill_we;

  assign cur_index = i_addr[TAG_LSB-1:INDEX_LSB];

  // refill address owns the RAM port while the line is written.
  assign array_index = (state == FILL) ? addr[TAG_LSB-1:INDEX_LSB] : cur_index;

  // RAM output only counts when it was read for this index.
  assign hit = valid[cur_index] && (index_r == cur_index) &&
               (tag_out == i_addr[31:TAG_LSB]);

  assign i_wait = i_req && !(hit && (state == IDLE || state == CHECK));

  assign beat      = req && !wait_in;
  assign last_beat = beat && (&beat_cnt);
  assign fill_we   = (state == FILL);

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (i_req) begin
          if (!valid[cur_index]) begin
            state_next = REFILL_ADDR;
          end else if (index_r != cur_index) begin
            state_next = CHECK;
          end else if (!hit) begin
            state_next = REFILL_ADDR;
          end
        end
      end
      CHECK:       state_next = hit ? IDLE : REFILL_ADDR;
      REFILL_ADDR: state_next = REFILL_DATA;
      REFILL_DATA: begin
        if (last_beat) begin
          state_next = FILL;
        end
      end
      FILL:        state_next = FILL_WAIT;
      FILL_WAIT:   state_next = IDLE;
      default:     state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= IDLE;
      index_r <= '0;
    end else begin
      state   <= state_next;
      index_r <= array_index;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= '0;
    end else if (fill_we) begin
      valid[array_index] <= 1'b1;
    end
  end

  // burst request, dropped after the last beat.
  always_ff @(posedge clk) begin
    if (rst) begin
      req <= 1'b0;
    end else if (state_next == REFILL_ADDR) begin
      req <= 1'b1;
    end else if (last_beat) begin
      req <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (state_next == REFILL_ADDR) begin
      addr <= {i_addr[31:INDEX_LSB], {INDEX_LSB{1'b0}}};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      beat_cnt <= '0;
    end else if (state_next == REFILL_ADDR) begin
      beat_cnt <= '0;
    end else if (beat) begin
      beat_cnt <= beat_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (beat) begin
      line_buf[beat_cnt*$bits(word_t) +: $bits(word_t)] <= rdata;
    end
  end

  assign i_data = line_out[i_addr[INDEX_LSB-1:OFFSET_LSB]*$bits(word_t) +: $bits(word_t)];

  cache_ram #(
    .WIDTH($bits(tag_t))
  ) u_tag (
    .clk  (clk),
    .addr (array_index),
    .we   (fill_we),
    .wdata(addr[31:TAG_LSB]),
    .rdata(tag_out)
  );

  cache_ram #(
    .WIDTH($bits(line_t))
  ) u_data (
    .clk  (clk),
    .addr (array_index),
    .we   (fill_we),
    .wdata(line_buf),
    .rdata(line_out)
  );

endmodule

`default_nettype wire

// ==== source/data_port.sv ====
`default_nettype none

module data_port (
  input  logic             clk,
  input  logic             rst,
  input  logic             d_req,
  input  logic             d_write,
  input  cache_pkg::addr_t d_addr,
  input  cache_pkg::word_t d_wdata,
  output cache_pkg::word_t d_rdata,
  output logic             d_wait,
  output logic             req,
  output logic             write,
  output cache_pkg::addr_t addr,
  output cache_pkg::word_t wdata,
  input  cache_pkg::word_t rdata,
  input  logic             wait_in
);
  import cache_pkg::*;

  typedef enum logic {DP_IDLE, DP_BUSY} dport_state_t;

  dport_state_t state;
  logic         done;
  logic         start;

  // done marks the cycle the core sees the result, so the held request is not reissued.
  assign start  = (state == DP_IDLE) && d_req && !done;
  assign d_wait = d_req && !done;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= DP_IDLE;
      req   <= 1'b0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        state <= DP_BUSY;
        req   <= 1'b1;
      end else if (state == DP_BUSY && !wait_in) begin
        state <= DP_IDLE;
        req   <= 1'b0;
        done  <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      write <= d_write;
      addr  <= d_addr;
      wdata <= d_wdata;
    end
    if (state == DP_BUSY && !wait_in) begin
      d_rdata <= rdata;
    end
  end

endmodule

`default_nettype wire

// ==== source/mem_arbiter.sv ====
`default_nettype none

module mem_arbiter (
  input  logic             clk,
  input  logic             rst,
  input  logic             req_i,
  input  logic             req_d,
  input  cache_pkg::addr_t addr_i,
  input  cache_pkg::addr_t addr_d,
  input  logic             write_d,
  input  cache_pkg::word_t wdata_d,
  output cache_pkg::word_t rdata,
  output logic             wait_i,
  output logic             wait_d,
  output logic             mem_req,
  output logic             mem_write,
  output cache_pkg::addr_t mem_addr,
  output cache_pkg::word_t mem_wdata,
  input  cache_pkg::word_t mem_rdata,
  input  logic             mem_wait
);

  typedef enum logic [1:0] {OWN_NONE, OWN_CACHE, OWN_DATA} owner_t;

  owner_t owner;
  owner_t owner_next;
  logic   cache_on;
  logic   data_on;

  assign cache_on = (owner == OWN_CACHE) && req_i;
  assign data_on  = (owner == OWN_DATA) && req_d;

  // new grant only once the current owner has let go; cache first.
  always_comb begin
    owner_next = owner;
    if (!cache_on && !data_on) begin
      if (req_i) begin
        owner_next = OWN_CACHE;
      end else if (req_d) begin
        owner_next = OWN_DATA;
      end else begin
        owner_next = OWN_NONE;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      owner <= OWN_NONE;
    end else begin
      owner <= owner_next;
    end
  end

  assign mem_req   = cache_on || data_on;
  assign mem_addr  = (owner == OWN_DATA) ? addr_d : addr_i;
  assign mem_write = (owner == OWN_DATA) && write_d;
  assign mem_wdata = wdata_d;

  assign rdata  = mem_rdata;
  assign wait_i = !(cache_on && !mem_wait);
  assign wait_d = !(data_on && !mem_wait);

endmodule

`default_nettype wire

// ==== source/cpu_mem_top.sv ====
`default_nettype none

module cpu_mem_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             i_req,
  input  cache_pkg::addr_t i_addr,
  output cache_pkg::word_t i_data,
  output logic             i_wait,
  input  logic             d_req,
  input  logic             d_write,
  input  cache_pkg::addr_t d_addr,
  input  cache_pkg::word_t d_wdata,
  output cache_pkg::word_t d_rdata,
  output logic             d_wait,
  output logic             mem_req,
  output logic             mem_write,
  output cache_pkg::addr_t mem_addr,
  output cache_pkg::word_t mem_wdata,
  input  cache_pkg::word_t mem_rdata,
  input  logic             mem_wait
);
  import cache_pkg::*;

  logic  ic_req;
  addr_t ic_addr;
  logic  ic_wait;
  logic  dp_req;
  logic  dp_write;
  addr_t dp_addr;
  word_t dp_wdata;
  logic  dp_wait;
  word_t bus_rdata;

  l1i_cache u_icache (
    .clk    (clk),
    .rst    (rst),
    .i_req  (i_req),
    .i_addr (i_addr),
    .i_data (i_data),
    .i_wait (i_wait),
    .req    (ic_req),
    .addr   (ic_addr),
    .rdata  (bus_rdata),
    .wait_in(ic_wait)
  );

  data_port u_dport (
    .clk    (clk),
    .rst    (rst),
    .d_req  (d_req),
    .d_write(d_write),
    .d_addr (d_addr),
    .d_wdata(d_wdata),
    .d_rdata(d_rdata),
    .d_wait (d_wait),
    .req    (dp_req),
    .write  (dp_write),
    .addr   (dp_addr),
    .wdata  (dp_wdata),
    .rdata  (bus_rdata),
    .wait_in(dp_wait)
  );

  mem_arbiter u_arb (
    .clk      (clk),
    .rst      (rst),
    .req_i    (ic_req),
    .req_d    (dp_req),
    .addr_i   (ic_addr),
    .addr_d   (dp_addr),
    .write_d  (dp_write),
    .wdata_d  (dp_wdata),
    .rdata    (bus_rdata),
    .wait_i   (ic_wait),
    .wait_d   (dp_wait),
    .mem_req  (mem_req),
    .mem_write(mem_write),
    .mem_addr (mem_addr),
    .mem_wdata(mem_wdata),
    .mem_rdata(mem_rdata),
    .mem_wait (mem_wait)
  );

endmodule

`default_nettype wire

// ==== bench/cpu_mem_asserts.sv ====
`default_nettype none

module cpu_mem_asserts (
  input logic             clk,
  input logic             rst,
  input logic             req_i,
  input logic             req_d,
  input logic             wait_i,
  input logic             wait_d,
  input logic             mem_req,
  input cache_pkg::addr_t mem_addr,
  input logic [1:0]       owner
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  // grant is locked for the whole transaction.
  owner_locked: assert property (
    @(posedge clk) disable iff (rst) mem_req |=> $stable(owner)
  ) else begin
    $error("arbiter owner changed during a bus transaction");
    fail_count++;
  end

  addr_held: assert property (
    @(posedge clk) disable iff (rst) (mem_req && $past(mem_req)) |-> $stable(mem_addr)
  ) else begin
    $error("mem_addr moved inside a burst");
    fail_count++;
  end

  // only one peer may complete a beat.
  one_peer: assert property (
    @(posedge clk) disable iff (rst) !(req_i && req_d && !wait_i && !wait_d)
  ) else begin
    $error("both peers released at once");
    fail_count++;
  end

endmodule

bind mem_arbiter cpu_mem_asserts u_asserts (
  .clk     (clk),
  .rst     (rst),
  .req_i   (req_i),
  .req_d   (req_d),
  .wait_i  (wait_i),
  .wait_d  (wait_d),
  .mem_req (mem_req),
  .mem_addr(mem_addr),
  .owner   (owner)
);

`default_nettype wire

// ==== bench/tb_cpu_mem.sv ====
`default_nettype none

module tb_cpu_mem;
  timeunit 1ns;
  timeprecision 100ps;
  import cache_pkg::*;

  localparam int RESET_CYCLES = 4;
  localparam int CLK_PERIOD   = 4;
  localparam int NS_PER_LINE  = 200;

  logic  clk;
  logic  rst;
  logic  i_req;
  addr_t i_addr;
  word_t i_data;
  logic  i_wait;
  logic  d_req;
  logic  d_write;
  addr_t d_addr;
  word_t d_wdata;
  word_t d_rdata;
  logic  d_wait;
  logic  mem_req;
  logic  mem_write;
  addr_t mem_addr;
  word_t mem_wdata;
  word_t mem_rdata = '0;
  logic  mem_wait  = 1'b1;

  integer seed   = 32'h6592_1c87;
  logic   loaded = 1'b0;

  // memory content and a log of bus transactions.
  word_t mem_model [addr_t];
  int    beat   = 0;
  logic  in_txn = 1'b0;
  addr_t txn_addr [$];
  logic  txn_write [$];
  word_t txn_wdata [$];
  int    txn_beats [$];

  logic [7:0] ops [$];
  addr_t      op_addr [$];
  word_t      op_wdata [$];
  word_t      op_exp [$];
  logic       op_miss [$];

  cpu_mem_top i_dut (.*);

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error: %s = %h, expected %h", name, got, exp));
    end
  endtask

  // unwritten words follow the address.
  function automatic word_t mem_read(input addr_t a);
    if (mem_model.exists(a)) begin
      return mem_model[a];
    end
    return a ^ 32'h5a5a_0000;
  endfunction

  function automatic addr_t line_base(input addr_t a);
    return a & 32'hffff_fff0;
  endfunction

  // bus slave, drives on the falling edge and samples mid cycle.
  always @(negedge clk) begin
    mem_wait  = ($random(seed) & 3) == 0;
    mem_rdata = mem_req ? mem_read(mem_addr + beat * 4) : '0;
    #1;
    if (mem_req) begin
      if (!in_txn) begin
        txn_addr.push_back(mem_addr);
        txn_write.push_back(mem_write);
        txn_wdata.push_back(mem_wdata);
        in_txn = 1'b1;
      end
      if (!mem_wait) begin
        if (mem_write) begin
          mem_model[mem_addr] = mem_wdata;
        end
        beat++;
      end
    end else if (in_txn) begin
      txn_beats.push_back(beat);
      in_txn = 1'b0;
      beat   = 0;
    end
  end

  task automatic apply_reset();
    @(negedge clk);
    rst = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic fetch(input addr_t a, output word_t data);
    @(negedge clk);
    i_req  = 1'b1;
    i_addr = a;
    #1;
    while (i_wait) begin
      @(negedge clk);
      #1;
    end
    data = i_data;
    @(negedge clk);
    i_req = 1'b0;
  endtask

  task automatic data_access(input logic wr, input addr_t a, input word_t wd,
                             output word_t rd);
    @(negedge clk);
    d_req   = 1'b1;
    d_write = wr;
    d_addr  = a;
    d_wdata = wd;
    #1;
    while (d_wait) begin
      @(negedge clk);
      #1;
    end
    rd = d_rdata;
    @(negedge clk);
    d_req = 1'b0;
  endtask

  task automatic check_txn(input int n, input addr_t a, input logic wr, input int beats);
    if (txn_beats.size() <= n) begin
      abort_run("an expected bus transaction never finished");
    end
    check_addr("mem_addr", txn_addr[n], a);
    check_bit("mem_write", txn_write[n], wr);
    if (txn_beats[n] != beats) begin
      abort_run($sformatf("transaction at %h had %0d beats, not %0d",
                          txn_addr[n], txn_beats[n], beats));
    end
  endtask

  initial begin
    wait (loaded);
    #(ops.size() * NS_PER_LINE + RESET_CYCLES * CLK_PERIOD);
    abort_run("watchdog expired before the last operation finished");
  end

  initial begin
    int         fd;
    int         c;
    int         n;
    int         n0;
    int         i;
    logic [7:0] ch;
    addr_t      a;
    word_t      wd;
    word_t      ex;
    logic       ms;
    word_t      got;
    word_t      got_d;

    rst     = 1'b1;
    i_req   = 1'b0;
    i_addr  = '0;
    d_req   = 1'b0;
    d_write = 1'b0;
    d_addr  = '0;
    d_wdata = '0;

    fd = $fopen("bench/cpu_mem_stim.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open bench/cpu_mem_stim.txt");
    end
    c = $fgetc(fd);
    while (c != -1) begin
      ch = c[7:0];
      if (ch == "#") begin
        while (c != -1 && c[7:0] != "\n") begin
          c = $fgetc(fd);
        end
      end else if (ch != " " && ch != "\n" && ch != "\r" && ch != "\t") begin
        n = $fscanf(fd, "%h %h %h %h", a, wd, ex, ms);
        if (n != 4) begin
          abort_run("malformed line in the stimulus file");
        end
        ops.push_back(ch);
        op_addr.push_back(a);
        op_wdata.push_back(wd);
        op_exp.push_back(ex);
        op_miss.push_back(ms);
      end
      c = $fgetc(fd);
    end
    $fclose(fd);
    loaded = 1'b1;

    apply_reset();
    i = 0;
    while (i < ops.size()) begin
      n0 = txn_addr.size();
      case (ops[i])
        "I": begin
          fetch(op_addr[i], got);
          check_word("i_data", got, op_exp[i]);
          check_bit("miss", txn_addr.size() != n0, op_miss[i]);
          if (op_miss[i]) begin
            check_txn(n0, line_base(op_addr[i]), 1'b0, WORDS_PER_LINE);
          end
        end
        "W": begin
          data_access(1'b1, op_addr[i], op_wdata[i], got);
          check_txn(n0, op_addr[i], 1'b1, 1);
          check_word("mem_wdata", txn_wdata[n0], op_wdata[i]);
        end
        "R": begin
          data_access(1'b0, op_addr[i], '0, got);
          check_word("d_rdata", got, op_exp[i]);
          check_txn(n0, op_addr[i], 1'b0, 1);
        end
        "P": begin
          if (i + 1 >= ops.size() || ops[i + 1] != "R") begin
            abort_run("parallel fetch is not followed by a data read");
          end
          fork
            fetch(op_addr[i], got);
            data_access(1'b0, op_addr[i + 1], '0, got_d);
          join
          check_word("i_data", got, op_exp[i]);
          check_word("d_rdata", got_d, op_exp[i + 1]);
          // cache owns the bus first.
          check_txn(n0, line_base(op_addr[i]), 1'b0, WORDS_PER_LINE);
          check_txn(n0 + 1, op_addr[i + 1], 1'b0, 1);
          i++;
        end
        "X": apply_reset();
        default: abort_run("unknown operation in the stimulus file");
      endcase
      i++;
    end

    if (i_dut.u_arb.u_asserts.fail_count != 0) begin
      abort_run("bus protocol assertions failed");
    end else begin
      $display("TEST PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== bench/cpu_mem_stim.txt ====
# op addr wdata expected miss, fields after op in hex. op: I fetch, R read, W write,
# X reset, P fetch that runs alongside the R line right after it.
I 00000104 00000000 5a5a0104 1
I 00000100 00000000 5a5a0100 0
I 0000010c 00000000 5a5a010c 0
I 00000104 00000000 5a5a0104 0
I 00000508 00000000 5a5a0508 1
I 0000050c 00000000 5a5a050c 0
I 00000104 00000000 5a5a0104 1
W 00002000 cafe1234 00000000 0
R 00002000 00000000 cafe1234 0
R 00002004 00000000 5a5a2004 0
P 00000840 00000000 5a5a0840 1
R 00002000 00000000 cafe1234 0
I 0000084c 00000000 5a5a084c 0
X 00000000 00000000 00000000 0
I 00000104 00000000 5a5a0104 1
I 00000108 00000000 5a5a0108 0

// ==== flist.f ====
source/cache_pkg.sv
source/cache_ram.sv
source/l1i_cache.sv
source/data_port.sv
source/mem_arbiter.sv
source/cpu_mem_top.sv
bench/cpu_mem_asserts.sv
bench/tb_cpu_mem.sv

// ==== Makefile ====
TOP := tb_cpu_mem

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator, run it, check the log"
	@echo "make clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
	  --top-module $(TOP) -f flist.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^TEST PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
